//--- hdl/dptx_consts.svh
/*
    Link layer constants
    Lane count, symbol and message widths, control message ID,
    training and scrambler reset symbols, scrambler seed, skew step
*/

`ifndef DPTX_CONSTS_SVH
`define DPTX_CONSTS_SVH

`define DPTX_LANES        4           // Physical lanes
`define DPTX_DAT_W        8           // Symbol data bits
`define DPTX_MSG_W        16          // Message word

`define DPTX_MSG_ID_CTL   16'h0010    // Control message

// K and D codes, 8b10b names
`define DPTX_SYM_SR       8'h1C       // Scrambler reset, K28.0
`define DPTX_SYM_K28_5    8'hBC       // Comma
`define DPTX_SYM_D11_6    8'hCB
`define DPTX_SYM_D10_2    8'h4A

`define DPTX_SCRM_SEED    16'hFFFF
`define DPTX_SKEW_STEP    2           // Cycles per lane index

`endif

//--- hdl/dptx_pkg.sv
/*
    Link layer types
    Lane symbol, four lane link bus, active lane code, pattern select
*/

package dptx_pkg;

`include "dptx_consts.svh"

    // One symbol on one lane
    typedef struct packed
    {
        logic                   k;      // Control symbol flag
        logic [`DPTX_DAT_W-1:0] dat;
    } lane_sym_t;

    // All lanes, lane 0 in the low bits
    typedef lane_sym_t [`DPTX_LANES-1:0] lnk_bus_t;

    // Active lanes, 0 none / 1 one / 2 two / 3 four
    typedef logic [1:0] lanes_t;

    // Training pattern select
    typedef enum logic
    {
        TPS1 = 1'b0,
        TPS2 = 1'b1
    } tps_t;

endpackage

//--- hdl/dptx_if.sv
/*
    Link layer interfaces
    Message bus with source and sink modports
    Control levels with decoder, scrambler and training modports
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

// System message bus
interface dptx_msg_if;

    logic                   som;    // First word, carries ID
    logic                   eom;    // Last word
    logic                   vld;
    logic [`DPTX_MSG_W-1:0] dat;

    modport src (output som, eom, vld, dat);
    modport snk (input som, eom, vld, dat);

endinterface

// Link control state
interface dptx_ctl_if
    import dptx_pkg::*;
;

    lanes_t lanes;      // Active lane code
    logic   trn_sel;    // 1 = training pattern
    logic   scrm_en;
    tps_t   tps;

    modport ctl  (output lanes, trn_sel, scrm_en, tps);
    modport scrm (input scrm_en);                      // Scrambler sees enable only
    modport trn  (input lanes, trn_sel, tps);

endinterface

//--- hdl/dptx_ctl.sv
/*
    Control message decoder
    Matches the control ID on the first word, takes the payload word
    and loads lanes, training select, scrambler enable and pattern on eom
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module dptx_ctl
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst_n,
    dptx_msg_if.snk     msg,
    dptx_ctl_if.ctl     ctl
);

    logic                   ctl_hit;    // Current message is ours
    logic                   pay_wrd;    // Next word is the payload
    logic [`DPTX_MSG_W-1:0] pay_dat;
    logic [`DPTX_MSG_W-1:0] pay_nxt;
    lanes_t                 lanes_r;
    logic                   trn_sel_r;
    logic                   scrm_en_r;
    tps_t                   tps_r;

    // Message tracking
    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            ctl_hit <= 1'b0;
            pay_wrd <= 1'b0;
        end
        else if (msg.vld)
        begin
            if (msg.som)
            begin
                // Single word message has no payload
                ctl_hit <= (msg.dat == `DPTX_MSG_ID_CTL) && !msg.eom;
                pay_wrd <= 1'b1;
            end
            else
            begin
                pay_wrd <= 1'b0;
                if (msg.eom)
                    ctl_hit <= 1'b0;    // Message done
            end
        end
    end

    // Payload capture
    always_ff @(posedge lnk_clk)
    begin
        if (msg.vld && !msg.som && pay_wrd)
            pay_dat <= msg.dat;
    end

    // Payload on the eom word itself comes straight from the bus
    assign pay_nxt = pay_wrd ? msg.dat : pay_dat;

    // Control state
    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            lanes_r   <= '0;
            trn_sel_r <= 1'b0;
            scrm_en_r <= 1'b0;
            tps_r     <= TPS1;
        end
        else if (msg.vld && msg.eom && !msg.som && ctl_hit)
        begin
            lanes_r   <= lanes_t'(pay_nxt[1:0]);
            trn_sel_r <= pay_nxt[2];
            scrm_en_r <= pay_nxt[3];
            tps_r     <= tps_t'(pay_nxt[4]);
        end
    end

    assign ctl.lanes   = lanes_r;
    assign ctl.trn_sel = trn_sel_r;
    assign ctl.scrm_en = scrm_en_r;
    assign ctl.tps     = tps_r;

endmodule

//--- hdl/dptx_scrm.sv
/*
    Lane scrambler
    One 16 bit LFSR per lane, x^16 + x^5 + x^4 + x^3 + 1, Galois form
    Eight steps per valid symbol, SR symbol reloads the seed
    Output registered, zero while input not valid
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module dptx_scrm
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst_n,
    dptx_ctl_if.scrm    ctl,
    input  lnk_bus_t    in_bus,
    input  logic        in_vld,
    output lnk_bus_t    out_bus,
    output logic        out_vld
);

    lnk_bus_t scr_bus;      // Scrambled symbols, all lanes

    // One LFSR step, feedback into taps 3, 4, 5 and bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15];
        return {s[14:5], s[4] ^ fb, s[3] ^ fb, s[2] ^ fb, s[1:0], fb};
    endfunction

    for (genvar i = 0; i < `DPTX_LANES; i++)
    begin : gen_lane
        logic [15:0] lfsr;
        logic [15:0] lfsr_nxt;
        lane_sym_t   sym_scr;

        always_comb
        begin
            lfsr_nxt = lfsr;
            sym_scr  = in_bus[i];
            // Bit 0 first, top bit of each step
            for (int j = 0; j < `DPTX_DAT_W; j++)
            begin
                if (!in_bus[i].k && ctl.scrm_en)
                    sym_scr.dat[j] = in_bus[i].dat[j] ^ lfsr_nxt[15];
                lfsr_nxt = lfsr_step(lfsr_nxt);
            end
            if (in_bus[i].k && (in_bus[i].dat == `DPTX_SYM_SR))
                lfsr_nxt = `DPTX_SCRM_SEED;   // Reload, no advance
        end

        // Runs with scrambling off too
        always_ff @(posedge lnk_clk)
        begin
            if (!rst_n)
                lfsr <= `DPTX_SCRM_SEED;
            else if (in_vld)
                lfsr <= lfsr_nxt;
        end

        assign scr_bus[i] = sym_scr;
    end

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            out_bus <= '0;
            out_vld <= 1'b0;
        end
        else
        begin
            out_bus <= in_vld ? scr_bus : '0;
            out_vld <= in_vld;
        end
    end

endmodule

//--- hdl/dptx_trn.sv
/*
    Training pattern generator and link selector
    TPS1 constant D10.2, TPS2 cycle K28.5 D11.6 D10.2 D10.2
    Main link or pattern per lane, lanes above the lane code forced to zero
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module dptx_trn
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst_n,
    dptx_ctl_if.trn     ctl,
    input  lnk_bus_t    in_bus,
    input  logic        in_vld,
    output lnk_bus_t    out_bus
);

    logic [1:0]             phase;      // TPS2 position
    lane_sym_t              pat_sym;
    logic [`DPTX_LANES-1:0] lane_en;
    lnk_bus_t               sel_bus;

    // Held at zero outside training, so each training run starts on K28.5
    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n || !ctl.trn_sel)
            phase <= '0;
        else
            phase <= phase + 2'd1;
    end

    always_comb
    begin
        if (ctl.tps == TPS1)
            pat_sym = '{k: 1'b0, dat: `DPTX_SYM_D10_2};
        else
        begin
            case (phase)
                2'd0:    pat_sym = '{k: 1'b1, dat: `DPTX_SYM_K28_5};
                2'd1:    pat_sym = '{k: 1'b0, dat: `DPTX_SYM_D11_6};
                default: pat_sym = '{k: 1'b0, dat: `DPTX_SYM_D10_2};
            endcase
        end
    end

    // Lane code to enable mask
    always_comb
    begin
        case (ctl.lanes)
            2'd1:    lane_en = 4'b0001;
            2'd2:    lane_en = 4'b0011;
            2'd3:    lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < `DPTX_LANES; i++)
        begin
            if (!lane_en[i])
                sel_bus[i] = '0;            // Inactive lane
            else if (ctl.trn_sel)
                sel_bus[i] = pat_sym;
            else if (in_vld)
                sel_bus[i] = in_bus[i];
            else
                sel_bus[i] = '0;
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
            out_bus <= '0;
        else
            out_bus <= sel_bus;
    end

endmodule

//--- hdl/dptx_skew.sv
/*
    Inter-lane skew
    Lane i delayed by DPTX_SKEW_STEP * i cycles, lane 0 passes straight
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module dptx_skew
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst_n,
    input  lnk_bus_t    in_bus,
    output lnk_bus_t    out_bus
);

    for (genvar i = 0; i < `DPTX_LANES; i++)
    begin : gen_lane
        localparam int DLY = `DPTX_SKEW_STEP * i;

        if (DLY == 0)
        begin : gen_thru
            assign out_bus[i] = in_bus[i];
        end
        else
        begin : gen_dly
            lane_sym_t dly_q [DLY];     // Shift line, [0] newest

            always_ff @(posedge lnk_clk)
            begin
                if (!rst_n)
                    dly_q <= '{default: '0};
                else
                begin
                    dly_q[0] <= in_bus[i];
                    for (int k = 1; k < DLY; k++)
                        dly_q[k] <= dly_q[k-1];
                end
            end

            assign out_bus[i] = dly_q[DLY-1];
        end
    end

endmodule

//--- hdl/dptx_lnk.sv
/*
    Link layer top, single stream
    Control decoder, scrambler, training selector and skew lines
    Plain message and lane ports packed into and out of the link bus
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module dptx_lnk
    import dptx_pkg::*;
(
    input  logic                                     lnk_clk,
    input  logic                                     rst_n,

    // System messages
    input  logic                                     msg_som,
    input  logic                                     msg_eom,
    input  logic                                     msg_vld,
    input  logic [`DPTX_MSG_W-1:0]                   msg_dat,

    // Main link in
    input  logic [`DPTX_LANES-1:0]                   lnk_k,
    input  logic [`DPTX_LANES-1:0][`DPTX_DAT_W-1:0]  lnk_dat,
    input  logic                                     lnk_vld,

    // PHY side
    output logic [`DPTX_LANES-1:0]                   tx_k,
    output logic [`DPTX_LANES-1:0][`DPTX_DAT_W-1:0]  tx_dat
);

    dptx_msg_if msg_if ();
    dptx_ctl_if ctl_if ();

    lnk_bus_t   lnk_bus;    // Packed input
    lnk_bus_t   scr_bus;
    logic       scr_vld;
    lnk_bus_t   trn_bus;
    lnk_bus_t   skw_bus;

    assign msg_if.som = msg_som;
    assign msg_if.eom = msg_eom;
    assign msg_if.vld = msg_vld;
    assign msg_if.dat = msg_dat;

    for (genvar i = 0; i < `DPTX_LANES; i++)
    begin : gen_pack
        assign lnk_bus[i] = '{k: lnk_k[i], dat: lnk_dat[i]};
        assign tx_k[i]    = skw_bus[i].k;
        assign tx_dat[i]  = skw_bus[i].dat;
    end

    dptx_ctl ctl0
    (
        .lnk_clk    (lnk_clk),
        .rst_n      (rst_n),
        .msg        (msg_if),
        .ctl        (ctl_if)
    );

    dptx_scrm scrm0
    (
        .lnk_clk    (lnk_clk),
        .rst_n      (rst_n),
        .ctl        (ctl_if),
        .in_bus     (lnk_bus),
        .in_vld     (lnk_vld),
        .out_bus    (scr_bus),
        .out_vld    (scr_vld)
    );

    dptx_trn trn0
    (
        .lnk_clk    (lnk_clk),
        .rst_n      (rst_n),
        .ctl        (ctl_if),
        .in_bus     (scr_bus),
        .in_vld     (scr_vld),
        .out_bus    (trn_bus)
    );

    dptx_skew skew0
    (
        .lnk_clk    (lnk_clk),
        .rst_n      (rst_n),
        .in_bus     (trn_bus),
        .out_bus    (skw_bus)
    );

endmodule

//--- sim/tb_dptx_lnk.sv
/*
    Testbench for the link layer top
    Clock, reset, random main-link traffic and control messages
    Reference model of scrambler, lane mask, training patterns and lane skew
    Comparison process on the PHY outputs, watchdog, per-test and final report
*/

`timescale 1ns/1ps

`include "dptx_consts.svh"

module tb_dptx_lnk
    import dptx_pkg::*;
;

    localparam int CLK_NS    = 10;
    localparam int LAT0      = 2;       // Lane 0 latency, in to out
    localparam int LEN_IDLE  = 30;
    localparam int LEN_RUN   = 60;
    localparam int LEN_HALF  = 40;
    localparam int LEN_TRN   = 24;
    localparam int DRAIN     = 12;      // Longer than the lane 3 latency
    localparam int MSG_LEN   = 2;
    localparam int N_MSG     = 8;
    localparam int WD_CYCLES = 3 + LEN_IDLE + 2 * LEN_RUN + 3 * LEN_HALF + 2 * LEN_TRN
                             + 6 * DRAIN + N_MSG * MSG_LEN + 100;

    logic                                    lnk_clk = 1'b0;
    logic                                    rst_n;
    logic                                    msg_som;
    logic                                    msg_eom;
    logic                                    msg_vld;
    logic [`DPTX_MSG_W-1:0]                  msg_dat;
    logic [`DPTX_LANES-1:0]                  lnk_k;
    logic [`DPTX_LANES-1:0][`DPTX_DAT_W-1:0] lnk_dat;
    logic                                    lnk_vld;
    logic [`DPTX_LANES-1:0]                  tx_k;
    logic [`DPTX_LANES-1:0][`DPTX_DAT_W-1:0] tx_dat;

    logic [31:0] rng;                       // xorshift state
    logic [15:0] ref_lfsr [`DPTX_LANES];
    lanes_t      ref_lanes;                 // Model control state
    logic        ref_trn_sel;
    logic        ref_scrm_en;
    tps_t        ref_tps;
    lane_sym_t   exp_q [`DPTX_LANES][$];    // Expected output per lane
    bit          pat_q [`DPTX_LANES][$];    // 1 = TPS2 slot with order check only
    int          tps2_pos [`DPTX_LANES];    // -1 until the phase is known
    int          tps2_hunt [`DPTX_LANES];
    int          ok_cnt    = 0;
    int          err_cnt   = 0;
    int          err_mark  = 0;
    int          test_num  = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;

    always #(CLK_NS / 2) lnk_clk = ~lnk_clk;

    dptx_lnk dut0
    (
        .lnk_clk    (lnk_clk),
        .rst_n      (rst_n),
        .msg_som    (msg_som),
        .msg_eom    (msg_eom),
        .msg_vld    (msg_vld),
        .msg_dat    (msg_dat),
        .lnk_k      (lnk_k),
        .lnk_dat    (lnk_dat),
        .lnk_vld    (lnk_vld),
        .tx_k       (tx_k),
        .tx_dat     (tx_dat)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // x^16 + x^5 + x^4 + x^3 + 1 shifted towards the top
    function automatic logic [15:0] lfsr_adv(input logic [15:0] s);
        logic [15:0] n;
        n = {s[14:0], 1'b0};
        if (s[15])
            n = n ^ 16'h0039;           // Taps 0, 3, 4, 5
        return n;
    endfunction

    // Scramble one symbol and advance or reload the lane LFSR
    function automatic lane_sym_t ref_scrm(input int ln, input lane_sym_t s);
        lane_sym_t   o;
        logic [15:0] st;
        o  = s;
        st = ref_lfsr[ln];
        for (int j = 0; j < `DPTX_DAT_W; j++)
        begin
            if (!s.k && ref_scrm_en)
                o.dat[j] = s.dat[j] ^ st[15];
            st = lfsr_adv(st);
        end
        if (s.k && (s.dat == `DPTX_SYM_SR))
            st = `DPTX_SCRM_SEED;
        ref_lfsr[ln] = st;
        return o;
    endfunction

    function automatic int lane_count(input lanes_t code);
        return (code == 2'd3) ? 4 : int'(code);
    endfunction

    // One input cycle through the model with expected symbols queued per lane
    function automatic void ref_model(input lnk_bus_t bus, input logic vld,
                                      input logic upd, input logic [`DPTX_MSG_W-1:0] pay);
        lnk_bus_t  scr;
        lane_sym_t e;
        bit        pat;
        int        n_act;
        scr = '0;
        if (vld)
        begin
            for (int i = 0; i < `DPTX_LANES; i++)
                scr[i] = ref_scrm(i, bus[i]);       // Enable from before this message
        end
        if (upd)                                    // Selector sees it one stage on
        begin
            ref_lanes   = lanes_t'(pay[1:0]);
            ref_trn_sel = pay[2];
            ref_scrm_en = pay[3];
            ref_tps     = tps_t'(pay[4]);
        end
        n_act = lane_count(ref_lanes);
        for (int i = 0; i < `DPTX_LANES; i++)
        begin
            e   = '0;
            pat = 1'b0;
            if (i < n_act)
            begin
                if (ref_trn_sel && (ref_tps == TPS1))
                    e = '{k: 1'b0, dat: `DPTX_SYM_D10_2};
                else if (ref_trn_sel)
                    pat = 1'b1;
                else
                    e = scr[i];                     // Zero when not valid
            end
            exp_q[i].push_back(e);
            pat_q[i].push_back(pat);
        end
    endfunction

    function automatic lane_sym_t tps2_sym(input int p);
        case (p)
            0:       return '{k: 1'b1, dat: `DPTX_SYM_K28_5};
            1:       return '{k: 1'b0, dat: `DPTX_SYM_D11_6};
            default: return '{k: 1'b0, dat: `DPTX_SYM_D10_2};
        endcase
    endfunction

    // Strict TPS2 order once locked and only a cycle tail before the first comma
    function automatic lane_sym_t tps2_expect(input int ln, input lane_sym_t act);
        if (tps2_pos[ln] >= 0)
        begin
            tps2_pos[ln] = (tps2_pos[ln] + 1) % 4;
            return tps2_sym(tps2_pos[ln]);
        end
        tps2_hunt[ln]++;
        if (act == tps2_sym(0))
        begin
            tps2_pos[ln] = 0;
            return act;
        end
        if ((act == tps2_sym(1)) && (tps2_hunt[ln] == 1))
        begin
            tps2_pos[ln] = 1;               // D11.6 fixes the phase
            return act;
        end
        if ((act == tps2_sym(2)) && (tps2_hunt[ln] <= 2))
            return act;                     // At most two D10.2 before the comma
        return tps2_sym(0);
    endfunction

    task automatic check_sym(input int ln, input lane_sym_t exp_s, input lane_sym_t act_s);
        if (act_s !== exp_s)
        begin
            $display("ERR %0t tx_k/tx_dat[%0d] exp %b/%02h act %b/%02h",
                     $time, ln, exp_s.k, exp_s.dat, act_s.k, act_s.dat);
            err_cnt++;
        end
        else
            ok_cnt++;
    endtask

    task automatic check_bus(input lnk_bus_t exp_b, input lnk_bus_t act_b);
        for (int i = 0; i < `DPTX_LANES; i++)
            check_sym(i, exp_b[i], act_b[i]);
    endtask

    task automatic drive_cycle(input lnk_bus_t bus, input logic vld,
                               input logic som, input logic eom, input logic mvld,
                               input logic [`DPTX_MSG_W-1:0] mdat, input logic upd);
        @(negedge lnk_clk);
        for (int i = 0; i < `DPTX_LANES; i++)
        begin
            lnk_k[i]   = bus[i].k;
            lnk_dat[i] = bus[i].dat;
        end
        lnk_vld = vld;
        msg_som = som;
        msg_eom = eom;
        msg_vld = mvld;
        msg_dat = mdat;
        ref_model(bus, vld, upd, mdat);
    endtask

    // ID word then payload word with the main link idle
    task automatic send_msg(input logic [`DPTX_MSG_W-1:0] id,
                            input logic [`DPTX_MSG_W-1:0] pay);
        drive_cycle('0, 1'b0, 1'b1, 1'b0, 1'b1, id, 1'b0);
        drive_cycle('0, 1'b0, 1'b0, 1'b1, 1'b1, pay, id == `DPTX_MSG_ID_CTL);
    endtask

    task automatic run_traffic(input int cycles, input bit with_sr);
        lnk_bus_t bus;
        logic     vld;
        for (int c = 0; c < cycles; c++)
        begin
            for (int i = 0; i < `DPTX_LANES; i++)
            begin
                rng        = xorshift32(rng);
                bus[i].dat = rng[7:0];
                bus[i].k   = (rng[11:8] == 4'h0);   // About one K in sixteen
            end
            rng = xorshift32(rng);
            vld = (rng[1:0] != 2'b00);              // Valid three cycles in four
            if (with_sr && (c % 16 == 7))
            begin
                bus[(c / 16) % `DPTX_LANES] = '{k: 1'b1, dat: `DPTX_SYM_SR};
                vld = 1'b1;
            end
            drive_cycle(bus, vld, 1'b0, 1'b0, 1'b0, '0, 1'b0);
        end
    endtask

    // Flush the pipeline and report this test's mismatches
    task automatic finish_test(input string name);
        int errs;
        repeat (DRAIN)
            drive_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
        @(posedge lnk_clk);                         // Last drain compare done by now
        errs     = err_cnt - err_mark;
        err_mark = err_cnt;
        test_num++;
        if (errs == 0)
        begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end
        else
        begin
            tests_bad++;
            $display("test %0d %s: %0d mismatches", test_num, name, errs);
        end
    endtask

    initial
    begin : stimulus
        rst_n   = 1'b0;
        lnk_k   = '0;
        lnk_dat = '0;
        lnk_vld = 1'b0;
        msg_som = 1'b0;
        msg_eom = 1'b0;
        msg_vld = 1'b0;
        msg_dat = '0;
        rng     = 32'h98a4d74a;
        ref_lanes   = '0;
        ref_trn_sel = 1'b0;
        ref_scrm_en = 1'b0;
        ref_tps     = TPS1;
        for (int i = 0; i < `DPTX_LANES; i++)
        begin
            ref_lfsr[i]  = `DPTX_SCRM_SEED;
            tps2_pos[i]  = -1;
            tps2_hunt[i] = 0;
            // Reset state still in flight when checking starts
            for (int d = 0; d < LAT0 - 1 + `DPTX_SKEW_STEP * i; d++)
            begin
                exp_q[i].push_back('0);
                pat_q[i].push_back(1'b0);
            end
        end
        repeat (3) @(posedge lnk_clk);
        @(negedge lnk_clk);
        rst_n = 1'b1;
        ref_model('0, 1'b0, 1'b0, '0);

        run_traffic(LEN_IDLE, 1'b0);
        finish_test("reset state, no lanes");

        send_msg(`DPTX_MSG_ID_CTL, 16'h0003);          // Four lanes plain
        run_traffic(LEN_RUN, 1'b0);
        finish_test("four lanes, scrambler off");

        send_msg(`DPTX_MSG_ID_CTL, 16'h000B);          // Scrambler on
        run_traffic(LEN_RUN, 1'b1);
        finish_test("four lanes, scrambler on, SR reload");

        send_msg(`DPTX_MSG_ID_CTL, 16'h0009);
        run_traffic(LEN_HALF, 1'b1);
        send_msg(`DPTX_MSG_ID_CTL, 16'h000A);
        run_traffic(LEN_HALF, 1'b1);
        finish_test("one lane, then two lanes");

        send_msg(`DPTX_MSG_ID_CTL, 16'h0007);          // TPS1 on four lanes
        run_traffic(LEN_TRN, 1'b0);
        send_msg(`DPTX_MSG_ID_CTL, 16'h0016);          // TPS2 on two lanes
        run_traffic(LEN_TRN, 1'b0);
        send_msg(`DPTX_MSG_ID_CTL, 16'h000B);
        finish_test("training patterns");

        send_msg(16'h0020, 16'h0004);                  // Foreign ID that would start training
        run_traffic(LEN_HALF, 1'b1);
        finish_test("foreign message ignored");

        $display("tests %0d ok, %0d failed; checks %0d ok, %0d failed",
                 tests_ok, tests_bad, ok_cnt, err_cnt);
        if ((err_cnt == 0) && (tests_bad == 0))
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Outputs sampled mid cycle on the falling edge
    initial
    begin : compare
        lnk_bus_t exp_bus;
        lnk_bus_t act_bus;
        bit       pat;
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge lnk_clk);
            for (int i = 0; i < `DPTX_LANES; i++)
            begin
                act_bus[i] = '{k: tx_k[i], dat: tx_dat[i]};
                if (exp_q[i].size() == 0)
                begin
                    $display("Lane %0d produced output with no expected symbol queued", i);
                    err_cnt++;
                    exp_bus[i] = act_bus[i];
                    pat        = 1'b0;
                end
                else
                begin
                    exp_bus[i] = exp_q[i].pop_front();
                    pat        = pat_q[i].pop_front();
                end
                if (pat)
                    exp_bus[i] = tps2_expect(i, act_bus[i]);
                else
                begin
                    tps2_pos[i]  = -1;                  // Out of TPS2 so resync next time
                    tps2_hunt[i] = 0;
                end
            end
            check_bus(exp_bus, act_bus);
        end
    end

    initial
    begin : watchdog
        #(WD_CYCLES * CLK_NS);
        $display("Timeout: the run did not end within %0d clock cycles", WD_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/dptx_pkg.sv
hdl/dptx_if.sv
hdl/dptx_ctl.sv
hdl/dptx_scrm.sv
hdl/dptx_trn.sv
hdl/dptx_skew.sv
hdl/dptx_lnk.sv
sim/tb_dptx_lnk.sv

//--- run.sh
#!/bin/sh
# Build and run the link layer testbench with Verilator, result read from sim.log

rm -f sim.log
verilator --binary --timing -f tb.f --top-module tb_dptx_lnk -o tb_dptx_lnk \
    && ./obj_dir/tb_dptx_lnk > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
